/* source/sdLogPkg.sv */
// shared vector types, sequencer state enum and FAT16 field offsets
`default_nettype none

package sdLogPkg;

  // ----------------------------------------------------------------------
  // vector types
  // ----------------------------------------------------------------------
  // absolute sector number on the card
  typedef logic [31:0] sectorAddrT;
  typedef logic [7:0]  byteT;
  // byte position inside one sector
  typedef logic [8:0]  byteIdxT;
  // file length in bytes, as stored in the dir entry
  typedef logic [31:0] fileLenT;

  // sequencer states
  typedef enum logic [3:0] {
    readMbr,
    readBoot,
    checkBoot,
    waitData,
    writeData,
    writeDir,
    halted
  } logStateT;

  // ----------------------------------------------------------------------
  // FAT16 byte offsets
  // ----------------------------------------------------------------------
  // partition 0 start LBA, inside the MBR
  localparam int partStartOfs  = 454;
  // boot sector (BPB) fields
  localparam int bytesPerSecOfs = 11;
  localparam int secPerClusOfs  = 13;
  localparam int rsvdSecsOfs    = 14;
  localparam int fatCountOfs    = 16;
  localparam int rootEntriesOfs = 17;
  localparam int secPerFatOfs   = 22;

  localparam int sectorBytes = 512;

endpackage

`default_nettype wire

/* source/uartRx.sv */
// UART receiver, 8N1, mid-bit sampling with stop-bit check
`default_nettype none
`timescale 1ns/1ns

module uartRx #(
  parameter int clkFreq  = 50_000_000,
  parameter int baudRate = 115_200
) (
  input  logic           clk,
  input  logic           rstn,
  input  logic           rx,
  output sdLogPkg::byteT rxByte,
  output logic           rxValid
);
  import sdLogPkg::*;

  // clocks per bit and counter width
  localparam int bitTicks  = clkFreq / baudRate;
  localparam int halfTicks = bitTicks / 2;
  localparam int cntW      = $clog2(bitTicks + 1);

  logic [1:0]      rxSync;
  logic            rxBusy;
  logic [cntW-1:0] baudCnt;
  // 0 start, 1..8 data, 9 stop
  logic [3:0]      bitCnt;
  byteT            shiftReg;

  assign rxByte = shiftReg;

  // two-flop synchronizer that idles high
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxSync <= 2'b11;
    end else begin
      rxSync <= {rxSync[0], rx};
    end
  end

  // data bit shift register
  always_ff @(posedge clk) begin
    if (rxBusy && baudCnt == '0 && bitCnt != 4'd0 && bitCnt <= 4'd8) begin
      // LSB first so shift in from the top
      shiftReg <= {rxSync[1], shiftReg[7:1]};
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      rxBusy  <= 1'b0;
      baudCnt <= '0;
      bitCnt  <= '0;
      rxValid <= 1'b0;
    end else begin
      rxValid <= 1'b0;
      if (!rxBusy) begin
        // start edge seen so aim for middle of start bit
        if (!rxSync[1]) begin
          rxBusy  <= 1'b1;
          baudCnt <= cntW'(halfTicks - 1);
          bitCnt  <= '0;
        end
      end else if (baudCnt != '0) begin
        baudCnt <= baudCnt - 1'b1;
      end else begin
        baudCnt <= cntW'(bitTicks - 1);
        bitCnt  <= bitCnt + 1'b1;
        if (bitCnt == 4'd0) begin
          // start bit high again means a glitch
          if (rxSync[1]) begin
            rxBusy <= 1'b0;
          end
        end else if (bitCnt == 4'd9) begin
          rxBusy <= 1'b0;
          // bad stop bit drops the frame
          rxValid <= rxSync[1];
        end
      end
    end
  end

endmodule

`default_nettype wire

/* source/byteFifo.sv */
// first-word-fall-through byte FIFO with fill count, drops writes when full
`default_nettype none
`timescale 1ns/1ns

module byteFifo #(
  parameter int fifoDepthLog2 = 11
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   push,
  input  sdLogPkg::byteT         pushByte,
  input  logic                   pop,
  output sdLogPkg::byteT         headByte,
  output logic [fifoDepthLog2:0] fillCount
);
  import sdLogPkg::*;

  localparam int depth = 1 << fifoDepthLog2;

  byteT                     mem [depth];
  logic [fifoDepthLog2-1:0] wrPtr;
  logic [fifoDepthLog2-1:0] rdPtr;
  logic                     full;
  logic                     doPush;
  logic                     doPop;

  // count tops out at depth, so the MSB alone means full
  assign full   = fillCount[fifoDepthLog2];
  assign doPush = push && !full;
  assign doPop  = pop && (fillCount != '0);

  // head is visible without a pop
  assign headByte = mem[rdPtr];

  always_ff @(posedge clk) begin
    if (doPush) begin
      mem[wrPtr] <= pushByte;
    end
  end

  // ----------------------------------------------------------------------
  // pointers and fill level
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      wrPtr     <= '0;
      rdPtr     <= '0;
      fillCount <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      case ({doPush, doPop})
        2'b10:   fillCount <= fillCount + 1'b1;
        2'b01:   fillCount <= fillCount - 1'b1;
        default: fillCount <= fillCount;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/bootSectorParser.sv */
// MBR and FAT16 boot-sector field capture, root and data sector address math
`default_nettype none
`timescale 1ns/1ns

module bootSectorParser #(
  parameter logic [15:0] fileCluster = 16'd3
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 mbrSel,
  input  logic                 rdValid,
  input  sdLogPkg::byteIdxT    rdIdx,
  input  sdLogPkg::byteT       rdByte,
  output sdLogPkg::sectorAddrT partStart,
  output sdLogPkg::sectorAddrT rootSector,
  output sdLogPkg::sectorAddrT dataSector,
  output logic                 bootValid
);
  import sdLogPkg::*;

  // captured BPB fields
  logic [15:0] bytesPerSec;
  logic [7:0]  secPerClus;
  logic [15:0] rsvdSecs;
  logic [7:0]  fatCount;
  logic [15:0] rootEntries;
  logic [15:0] secPerFat;

  // ----------------------------------------------------------------------
  // capture, all fields little endian
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      partStart   <= '0;
      bytesPerSec <= '0;
      secPerClus  <= '0;
      rsvdSecs    <= '0;
      fatCount    <= '0;
      rootEntries <= '0;
      secPerFat   <= '0;
    end else if (rdValid && mbrSel) begin
      // partition 0 LBA, four bytes
      if (rdIdx >= byteIdxT'(partStartOfs) && rdIdx <= byteIdxT'(partStartOfs + 3)) begin
        partStart[8 * (int'(rdIdx) - partStartOfs) +: 8] <= rdByte;
      end
    end else if (rdValid) begin
      case (rdIdx)
        byteIdxT'(bytesPerSecOfs):     bytesPerSec[7:0]  <= rdByte;
        byteIdxT'(bytesPerSecOfs + 1): bytesPerSec[15:8] <= rdByte;
        byteIdxT'(secPerClusOfs):      secPerClus        <= rdByte;
        byteIdxT'(rsvdSecsOfs):        rsvdSecs[7:0]     <= rdByte;
        byteIdxT'(rsvdSecsOfs + 1):    rsvdSecs[15:8]    <= rdByte;
        byteIdxT'(fatCountOfs):        fatCount          <= rdByte;
        byteIdxT'(rootEntriesOfs):     rootEntries[7:0]  <= rdByte;
        byteIdxT'(rootEntriesOfs + 1): rootEntries[15:8] <= rdByte;
        byteIdxT'(secPerFatOfs):       secPerFat[7:0]    <= rdByte;
        byteIdxT'(secPerFatOfs + 1):   secPerFat[15:8]   <= rdByte;
        default: ;
      endcase
    end
  end

  // ----------------------------------------------------------------------
  // address math
  // ----------------------------------------------------------------------
  // root dir follows reserved area and all FAT copies
  assign rootSector = partStart + sectorAddrT'(rsvdSecs)
                    + sectorAddrT'(fatCount) * sectorAddrT'(secPerFat);

  // 32-byte entries, 16 per sector; clusters numbered from 2
  assign dataSector = rootSector + sectorAddrT'(rootEntries[15:4])
                    + sectorAddrT'(fileCluster - 16'd2) * sectorAddrT'(secPerClus);

  // only 512-byte sectors, at least one FAT
  assign bootValid = (bytesPerSec == 16'(sectorBytes)) && (fatCount != 8'd0);

endmodule

`default_nettype wire

/* source/logSequencer.sv */
// log FSM: boot reads, data sector writes, periodic root directory rewrite
`default_nettype none
`timescale 1ns/1ns

module logSequencer #(
  parameter int fifoDepthLog2     = 11,
  parameter int dirUpdateInterval = 2
) (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   blkDone,
  input  logic                   wrTake,
  input  logic [fifoDepthLog2:0] fillCount,
  input  sdLogPkg::byteT         headByte,
  input  logic                   bootValid,
  input  sdLogPkg::sectorAddrT   partStart,
  input  sdLogPkg::sectorAddrT   rootSector,
  input  sdLogPkg::sectorAddrT   dataSector,
  input  sdLogPkg::byteT         dirByte,
  output logic                   blkReq,
  output logic                   blkWrite,
  output sdLogPkg::sectorAddrT   blkAddr,
  output logic                   mbrSel,
  output logic                   pop,
  output sdLogPkg::byteT         wrByte,
  output sdLogPkg::byteIdxT      byteIdx,
  output sdLogPkg::sectorAddrT   sectorCount,
  output sdLogPkg::logStateT     logState
);
  import sdLogPkg::*;

  localparam int fillW = fifoDepthLog2 + 1;
  localparam int ivW   = $clog2(dirUpdateInterval + 1);
  // beyond this the byte length no longer fits 32 bits
  localparam sectorAddrT maxSectors = 32'h007F_FFFF;

  // data sectors since the last dir rewrite
  logic [ivW-1:0] sinceDir;
  logic           writing;
  logic           dirDue;

  // ----------------------------------------------------------------------
  // combinational outputs
  // ----------------------------------------------------------------------
  // MBR capture only during the very first read
  assign mbrSel  = (logState == readMbr);
  assign writing = (logState == writeData) || (logState == writeDir);
  // FWFT head goes out on the same edge the host takes it
  assign pop     = (logState == writeData) && wrTake;
  assign wrByte  = (logState == writeDir) ? dirByte : headByte;

  // rewrite on interval, or once more when the file is full
  assign dirDue = (sinceDir == ivW'(dirUpdateInterval - 1))
                || (sectorCount == maxSectors - 1);

  // ----------------------------------------------------------------------
  // state machine and block request
  // ----------------------------------------------------------------------
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      logState    <= readMbr;
      blkReq      <= 1'b0;
      blkWrite    <= 1'b0;
      blkAddr     <= '0;
      byteIdx     <= '0;
      sectorCount <= '0;
      sinceDir    <= '0;
    end else begin
      // byte position, wraps after 512
      if (writing && wrTake) begin
        byteIdx <= byteIdx + 1'b1;
      end

      case (logState)
        // sector 0, raised on the first cycle out of reset
        readMbr: begin
          if (blkDone) begin
            blkReq   <= 1'b0;
            logState <= readBoot;
          end else if (!blkReq) begin
            blkReq   <= 1'b1;
            blkWrite <= 1'b0;
            blkAddr  <= '0;
          end
        end

        // boot sector at partition start
        readBoot: begin
          if (blkDone) begin
            blkReq   <= 1'b0;
            logState <= checkBoot;
          end else if (!blkReq) begin
            blkReq   <= 1'b1;
            blkWrite <= 1'b0;
            blkAddr  <= partStart;
          end
        end

        // single cycle, retry the boot read on bad fields
        checkBoot: begin
          logState <= bootValid ? waitData : readBoot;
        end

        // a full sector buffered, request straight away
        waitData: begin
          if (fillCount >= fillW'(sectorBytes)) begin
            blkReq   <= 1'b1;
            blkWrite <= 1'b1;
            blkAddr  <= dataSector + sectorCount;
            byteIdx  <= '0;
            logState <= writeData;
          end
        end

        writeData: begin
          if (blkDone) begin
            blkReq      <= 1'b0;
            sectorCount <= sectorCount + 1'b1;
            if (dirDue) begin
              sinceDir <= '0;
              logState <= writeDir;
            end else begin
              sinceDir <= sinceDir + 1'b1;
              logState <= waitData;
            end
          end
        end

        // root dir sector carrying the new length
        writeDir: begin
          if (blkDone) begin
            blkReq   <= 1'b0;
            logState <= (sectorCount == maxSectors) ? halted : waitData;
          end else if (!blkReq) begin
            blkReq   <= 1'b1;
            blkWrite <= 1'b1;
            blkAddr  <= rootSector;
            byteIdx  <= '0;
          end
        end

        // file full, no more traffic
        halted: begin
          blkReq <= 1'b0;
        end

        default: begin
          blkReq   <= 1'b0;
          logState <= halted;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/dirEntryBuilder.sv */
// root directory sector bytes, entry 0 with name, cluster and current length
`default_nettype none
`timescale 1ns/1ns

module dirEntryBuilder #(
  parameter logic [15:0] fileCluster = 16'd3,
  parameter logic [87:0] fileName    = "LOG     DAT"
) (
  input  sdLogPkg::byteIdxT    byteIdx,
  input  sdLogPkg::sectorAddrT sectorCount,
  output sdLogPkg::byteT       dirByte
);
  import sdLogPkg::*;

  // whole sectors only, low 9 bits always zero
  fileLenT fileLen;

  assign fileLen = {sectorCount[22:0], 9'd0};

  // ----------------------------------------------------------------------
  // 32-byte entry 0, rest of sector empty
  // ----------------------------------------------------------------------
  always_comb begin
    dirByte = '0;
    case (byteIdx) inside
      // 8.3 name, first char in the top byte of the string
      [9'd0:9'd10]: begin
        dirByte = fileName[8 * (10 - int'(byteIdx)) +: 8];
      end
      // archive attribute
      9'd11: begin
        dirByte = 8'h20;
      end
      // first cluster, little endian
      9'd26: begin
        dirByte = fileCluster[7:0];
      end
      9'd27: begin
        dirByte = fileCluster[15:8];
      end
      // file size
      [9'd28:9'd31]: begin
        dirByte = fileLen[8 * (int'(byteIdx) - 28) +: 8];
      end
      default: begin
        dirByte = '0;
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/sdLogger.sv */
// FAT16 logger top: UART receiver, FIFO, boot parser, sequencer, dir builder
`default_nettype none
`timescale 1ns/1ns

module sdLogger #(
  parameter int          clkFreq           = 50_000_000,
  parameter int          baudRate          = 115_200,
  parameter int          fifoDepthLog2     = 11,
  parameter logic [15:0] fileCluster       = 16'd3,
  parameter logic [87:0] fileName          = "LOG     DAT",
  parameter int          dirUpdateInterval = 2
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 rx,
  // block port to the sector host
  input  logic                 blkDone,
  input  logic                 rdValid,
  input  sdLogPkg::byteIdxT    rdIdx,
  input  sdLogPkg::byteT       rdByte,
  input  logic                 wrTake,
  output logic                 blkReq,
  output logic                 blkWrite,
  output sdLogPkg::sectorAddrT blkAddr,
  output sdLogPkg::byteT       wrByte,
  output sdLogPkg::logStateT   logState
);
  import sdLogPkg::*;

  byteT                   rxByte;
  logic                   rxValid;
  byteT                   headByte;
  logic [fifoDepthLog2:0] fillCount;
  logic                   pop;
  logic                   mbrSel;
  sectorAddrT             partStart;
  sectorAddrT             rootSector;
  sectorAddrT             dataSector;
  logic                   bootValid;
  byteT                   dirByte;
  byteIdxT                byteIdx;
  sectorAddrT             sectorCount;

  // ----------------------------------------------------------------------
  // UART into FIFO
  // ----------------------------------------------------------------------
  uartRx #(.clkFreq(clkFreq), .baudRate(baudRate)) uartRx0 (
    .clk(clk), .rstn(rstn), .rx(rx), .rxByte(rxByte), .rxValid(rxValid)
  );

  byteFifo #(.fifoDepthLog2(fifoDepthLog2)) byteFifo0 (
    .clk(clk), .rstn(rstn), .push(rxValid), .pushByte(rxByte),
    .pop(pop), .headByte(headByte), .fillCount(fillCount)
  );

  // ----------------------------------------------------------------------
  // filesystem and sequencing
  // ----------------------------------------------------------------------
  bootSectorParser #(.fileCluster(fileCluster)) bootSectorParser0 (
    .clk(clk), .rstn(rstn), .mbrSel(mbrSel), .rdValid(rdValid),
    .rdIdx(rdIdx), .rdByte(rdByte), .partStart(partStart),
    .rootSector(rootSector), .dataSector(dataSector), .bootValid(bootValid)
  );

  logSequencer #(
    .fifoDepthLog2(fifoDepthLog2), .dirUpdateInterval(dirUpdateInterval)
  ) logSequencer0 (
    .clk(clk), .rstn(rstn), .blkDone(blkDone), .wrTake(wrTake),
    .fillCount(fillCount), .headByte(headByte), .bootValid(bootValid),
    .partStart(partStart), .rootSector(rootSector), .dataSector(dataSector),
    .dirByte(dirByte), .blkReq(blkReq), .blkWrite(blkWrite), .blkAddr(blkAddr),
    .mbrSel(mbrSel), .pop(pop), .wrByte(wrByte), .byteIdx(byteIdx),
    .sectorCount(sectorCount), .logState(logState)
  );

  dirEntryBuilder #(.fileCluster(fileCluster), .fileName(fileName)) dirEntryBuilder0 (
    .byteIdx(byteIdx), .sectorCount(sectorCount), .dirByte(dirByte)
  );

endmodule

`default_nettype wire

/* tests/sdCardModel.sv */
// sector host model: preset MBR and boot sector, random gaps, log of every block request
`default_nettype none
`timescale 1ns/1ns

module sdCardModel #(
  parameter logic [31:0] partStartVal = 32'h0000_0800,
  parameter logic [15:0] rsvdSecs     = 16'd4,
  parameter logic [7:0]  fatCount     = 8'd2,
  parameter logic [15:0] rootEntries  = 16'd512,
  parameter logic [15:0] secPerFat    = 16'd200,
  parameter logic [7:0]  secPerClus   = 8'd4,
  parameter logic [31:0] lcgSeed      = 32'h5411,
  parameter int          maxOps       = 8
) (
  input  logic                 clk,
  input  logic                 rstn,
  input  logic                 blkReq,
  input  logic                 blkWrite,
  input  sdLogPkg::sectorAddrT blkAddr,
  input  sdLogPkg::byteT       wrByte,
  output logic                 blkDone,
  output logic                 rdValid,
  output sdLogPkg::byteIdxT    rdIdx,
  output sdLogPkg::byteT       rdByte,
  output logic                 wrTake
);
  import sdLogPkg::*;

  // request log, read back by the testbench
  int          opCount;
  sectorAddrT  opAddr [maxOps];
  logic        opWrite [maxOps];
  byteT        opData [maxOps * sectorBytes];
  logic [31:0] lcgState;
  // first boot-sector serving is corrupt
  int          bootServes;

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // ----------------------------------------------------------------------
  // sector contents
  // ----------------------------------------------------------------------
  function automatic byteT presetByte(input sectorAddrT addr, input int idx,
                                      input logic badBps);
    byteT b;
    // fill mixes every address byte with the index
    b = addr[7:0] ^ addr[15:8] ^ addr[23:16] ^ addr[31:24] ^ byteT'(idx) ^ 8'hA5;
    if (addr == 32'd0) begin
      if (idx >= 454 && idx <= 457) begin
        b = partStartVal[8 * (idx - 454) +: 8];
      end else if (idx == 510) begin
        b = 8'h55;
      end else if (idx == 511) begin
        b = 8'hAA;
      end
    end else if (addr == partStartVal) begin
      case (idx)
        11: b = 8'h00;
        // 512 normally, 1024 when corrupt
        12: b = badBps ? 8'h04 : 8'h02;
        13: b = secPerClus;
        14: b = rsvdSecs[7:0];
        15: b = rsvdSecs[15:8];
        16: b = fatCount;
        17: b = rootEntries[7:0];
        18: b = rootEntries[15:8];
        22: b = secPerFat[7:0];
        23: b = secPerFat[15:8];
        default: ;
      endcase
    end
    return b;
  endfunction

  // ----------------------------------------------------------------------
  // block service, one byte per active cycle
  // ----------------------------------------------------------------------
  task automatic serveBlock();
    sectorAddrT addr;
    logic       isWr;
    logic       badBoot;
    int         slot;
    int         gap;
    addr    = blkAddr;
    isWr    = blkWrite;
    slot    = opCount;
    badBoot = !isWr && (addr == partStartVal) && (bootServes == 0);
    if (!isWr && addr == partStartVal) begin
      bootServes++;
    end
    for (int i = 0; i < sectorBytes; i++) begin
      // host slowness, 0 to 3 idle cycles
      gap = int'(nextRand() >> 30);
      repeat (gap) @(negedge clk);
      if (isWr) begin
        // wrByte settled since the last rising edge
        if (slot < maxOps) begin
          opData[slot * sectorBytes + i] = wrByte;
        end
        wrTake = 1'b1;
      end else begin
        rdValid = 1'b1;
        rdIdx   = byteIdxT'(i);
        rdByte  = presetByte(addr, i, badBoot);
      end
      @(negedge clk);
      wrTake  = 1'b0;
      rdValid = 1'b0;
    end
    if (slot < maxOps) begin
      opAddr[slot]  = addr;
      opWrite[slot] = isWr;
    end
    opCount++;
    blkDone = 1'b1;
    @(negedge clk);
    blkDone = 1'b0;
  endtask

  initial begin
    blkDone    = 1'b0;
    rdValid    = 1'b0;
    rdIdx      = '0;
    rdByte     = '0;
    wrTake     = 1'b0;
    lcgState   = lcgSeed;
    opCount    = 0;
    bootServes = 0;
    forever begin
      @(negedge clk);
      if (rstn && blkReq && !blkDone) begin
        serveBlock();
      end
    end
  end

endmodule

`default_nettype wire

/* tests/sdLogger_chk.sv */
// block port assertions bound into the logger top
`default_nettype none
`timescale 1ns/1ns

module sdLoggerChk (
  input logic                 clk,
  input logic                 rstn,
  input logic                 blkReq,
  input logic                 blkWrite,
  input sdLogPkg::sectorAddrT blkAddr,
  input logic                 blkDone,
  input logic                 wrTake
);

  // assertion failures seen so far
  int assertFails = 0;

  // request fields frozen until the host finishes
  reqStable: assert property (@(posedge clk) disable iff (!rstn)
    blkReq && $past(blkReq) |-> $stable(blkAddr) && $stable(blkWrite))
  else begin
    assertFails++;
    $error("block address or direction changed during a request");
  end

  // host takes bytes only from a write request
  takeInWrite: assert property (@(posedge clk) disable iff (!rstn)
    wrTake |-> blkReq && blkWrite)
  else begin
    assertFails++;
    $error("wrTake seen outside a write request");
  end

  // request gone the cycle after done
  dropAfterDone: assert property (@(posedge clk) disable iff (!rstn)
    blkDone |=> !blkReq)
  else begin
    assertFails++;
    $error("blkReq still high one cycle after blkDone");
  end

endmodule

bind sdLogger sdLoggerChk blkChk0 (
  .clk(clk), .rstn(rstn), .blkReq(blkReq), .blkWrite(blkWrite),
  .blkAddr(blkAddr), .blkDone(blkDone), .wrTake(wrTake)
);

`default_nettype wire

/* tests/sdLoggerTb.sv */
// logger testbench: clock, reset, LCG UART stimulus, FAT16 reference model and checks
`default_nettype none
`timescale 1ns/1ns

module sdLoggerTb;
  import sdLogPkg::*;

  // 10 clocks per UART bit
  localparam int          clkFreq      = 100_000_000;
  localparam int          baudRate     = 10_000_000;
  localparam int          bitTicks     = clkFreq / baudRate;
  localparam logic [15:0] fileCluster  = 16'd5;
  localparam logic [87:0] fileName     = "DATALOG TXT";
  localparam int          numBytes     = 1600;
  localparam int          opTimeout    = 300_000;
  // preset filesystem on the card
  localparam logic [31:0] partStartVal = 32'h0001_0230;
  localparam logic [15:0] rsvdSecs     = 16'd6;
  localparam logic [7:0]  fatCount     = 8'd2;
  localparam logic [15:0] rootEntries  = 16'd512;
  localparam logic [15:0] secPerFat    = 16'd243;
  localparam logic [7:0]  secPerClus   = 8'd4;

  logic       clk = 1'b0;
  logic       rstn;
  logic       rx;
  logic       blkDone;
  logic       rdValid;
  byteIdxT    rdIdx;
  byteT       rdByte;
  logic       wrTake;
  logic       blkReq;
  logic       blkWrite;
  sectorAddrT blkAddr;
  byteT       wrByte;
  logStateT   logState;

  int          errCount;
  int          checkCount;
  logic [31:0] lcgState;
  byteT        sentQ [$];
  sectorAddrT  expRoot;
  sectorAddrT  expData;

  always #5 clk = ~clk;

  sdLogger #(
    .clkFreq(clkFreq), .baudRate(baudRate), .fifoDepthLog2(11),
    .fileCluster(fileCluster), .fileName(fileName), .dirUpdateInterval(2)
  ) dut0 (
    .clk(clk), .rstn(rstn), .rx(rx), .blkDone(blkDone), .rdValid(rdValid),
    .rdIdx(rdIdx), .rdByte(rdByte), .wrTake(wrTake), .blkReq(blkReq),
    .blkWrite(blkWrite), .blkAddr(blkAddr), .wrByte(wrByte), .logState(logState)
  );

  sdCardModel #(
    .partStartVal(partStartVal), .rsvdSecs(rsvdSecs), .fatCount(fatCount),
    .rootEntries(rootEntries), .secPerFat(secPerFat), .secPerClus(secPerClus),
    .lcgSeed(32'h5411), .maxOps(8)
  ) card0 (
    .clk(clk), .rstn(rstn), .blkReq(blkReq), .blkWrite(blkWrite),
    .blkAddr(blkAddr), .wrByte(wrByte), .blkDone(blkDone), .rdValid(rdValid),
    .rdIdx(rdIdx), .rdByte(rdByte), .wrTake(wrTake)
  );

  function automatic logic [31:0] nextRand();
    lcgState = lcgState * 32'd1664525 + 32'd1013904223;
    return lcgState;
  endfunction

  // expected root dir sector, entry 0 only
  function automatic byteT expDirByte(input int idx, input logic [31:0] len);
    if (idx <= 10) return fileName[87 - 8 * idx -: 8];
    if (idx == 11) return 8'h20;
    if (idx == 26) return fileCluster[7:0];
    if (idx == 27) return fileCluster[15:8];
    if (idx >= 28 && idx <= 31) return len[8 * (idx - 28) +: 8];
    return 8'h00;
  endfunction

  task automatic checkValue(input string name, input logic [31:0] expVal,
                            input logic [31:0] actVal);
    checkCount++;
    assert (actVal === expVal) else begin
      errCount++;
      $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, expVal, actVal);
    end
  endtask

  // 8N1 frame, LSB first, then a short idle gap
  task automatic sendByte(input byteT b);
    int gap;
    sentQ.push_back(b);
    rx = 1'b0;
    repeat (bitTicks) @(negedge clk);
    for (int i = 0; i < 8; i++) begin
      rx = b[i];
      repeat (bitTicks) @(negedge clk);
    end
    rx = 1'b1;
    repeat (bitTicks) @(negedge clk);
    gap = int'(nextRand() >> 28);
    repeat (gap) @(negedge clk);
  endtask

  task automatic waitOps(input int target, output logic ok);
    int cycles;
    cycles = 0;
    while (card0.opCount < target && cycles < opTimeout) begin
      @(negedge clk);
      cycles++;
    end
    ok = (card0.opCount >= target);
    assert (ok) else begin
      errCount++;
      $display("timeout: only %0d of %0d block requests were served", card0.opCount, target);
    end
  endtask

  // ----------------------------------------------------------------------
  // main sequence
  // ----------------------------------------------------------------------
  initial begin
    logic       waitOk;
    int         opIdx;
    int         totalErr;
    sectorAddrT expAddr [7];
    logic       expWr [7];
    rstn       = 1'b0;
    rx         = 1'b1;
    errCount   = 0;
    checkCount = 0;
    lcgState   = 32'h5411;

    // reference address math from the preset fields
    expRoot = partStartVal + sectorAddrT'(rsvdSecs)
            + sectorAddrT'(fatCount) * sectorAddrT'(secPerFat);
    expData = expRoot + sectorAddrT'(rootEntries) / 16
            + sectorAddrT'(fileCluster - 16'd2) * sectorAddrT'(secPerClus);
    // two MBR/boot reads, boot retry, then d0 d1 dir d2
    expAddr = '{32'd0, partStartVal, partStartVal, expData, expData + 1,
                expRoot, expData + 2};
    expWr   = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1, 1'b1};

    repeat (3) @(negedge clk);
    checkValue("blkReq in reset", 0, blkReq);
    checkValue("state in reset", readMbr, logState);
    rstn = 1'b1;
    @(negedge clk);
    checkValue("blkReq after reset", 1, blkReq);
    checkValue("first request direction", 0, blkWrite);
    checkValue("first request address", 0, blkAddr);

    for (int n = 0; n < numBytes; n++) begin
      sendByte(byteT'(nextRand() >> 24));
    end

    waitOps(7, waitOk);
    if (waitOk) begin
      // leftover bytes must stay in the FIFO
      repeat (50 * bitTicks * 10) @(negedge clk);
      checkValue("request count after leftover", 7, card0.opCount);
      checkValue("leftover fill", numBytes - 3 * sectorBytes, dut0.fillCount);
      checkValue("final state", waitData, logState);
      for (int k = 0; k < 7; k++) begin
        checkValue($sformatf("request %0d address", k), expAddr[k], card0.opAddr[k]);
        checkValue($sformatf("request %0d write", k), expWr[k], card0.opWrite[k]);
      end
      for (int s = 0; s < 3; s++) begin
        opIdx = (s < 2) ? 3 + s : 6;
        for (int i = 0; i < sectorBytes; i++) begin
          checkValue($sformatf("data sector %0d byte %0d", s, i),
                     sentQ[s * sectorBytes + i], card0.opData[opIdx * sectorBytes + i]);
        end
      end
      // dir rewrite after two sectors
      for (int i = 0; i < sectorBytes; i++) begin
        checkValue($sformatf("dir sector byte %0d", i), expDirByte(i, 32'd1024),
                   card0.opData[5 * sectorBytes + i]);
      end
    end

    totalErr = errCount + dut0.blkChk0.assertFails;
    $display("checks %0d, errors %0d, assertion failures %0d",
             checkCount, errCount, dut0.blkChk0.assertFails);
    if (totalErr == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sdLogger.f */
source/sdLogPkg.sv
source/uartRx.sv
source/byteFifo.sv
source/bootSectorParser.sv
source/logSequencer.sv
source/dirEntryBuilder.sv
source/sdLogger.sv
tests/sdCardModel.sv
tests/sdLogger_chk.sv
tests/sdLoggerTb.sv

/* Bender.yml */
package:
  name: sdLogger

sources:
  - source/sdLogPkg.sv
  - source/uartRx.sv
  - source/byteFifo.sv
  - source/bootSectorParser.sv
  - source/logSequencer.sv
  - source/dirEntryBuilder.sv
  - source/sdLogger.sv
  - target: test
    files:
      - tests/sdCardModel.sv
      - tests/sdLogger_chk.sv
      - tests/sdLoggerTb.sv
